// File: all.f
madam_pkg.sv
madam_ctl_regs.sv
madam_dma_stack.sv
madam_bus_arbiter.sv
madam.sv
tb_madam.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then search the log for the fail message
verilator --binary --timing -f all.f --top-module tb_madam -o sim_madam > build.log 2>&1 &&
./obj_dir/sim_madam > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

// File: tb_madam.sv
// ----------------------------------------------------------
// table-driven testbench for the MADAM CPU-side logic
// one table entry per clock, driven on the rising edge
// outputs are checked on the falling edge of the same cycle
// dma stack data is random from a fixed seed
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_madam;

	import madam_pkg::*;

	localparam logic [1:0] K_WR  = 2'd0;	// write, no read check
	localparam logic [1:0] K_RD  = 2'd1;	// read, check cpu_dout
	localparam logic [1:0] K_DEC = 2'd2;	// read, check chip selects and mem port
	localparam int RESET_CYCLES = 10;
	localparam int CLK_NS       = 40;

	typedef struct packed {
		logic [1:0] kind;
		cpu_addr_t  addr;
		cpu_data_t  data;
		cpu_data_t  exp;	// read word, or {dram, vram, bios} on decode
		logic       trig;	// pbus_dma_trig level in this cycle
		logic [2:0] test;
	} entry_t;

	logic      clk_25m;
	logic      reset_n;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_din;
	logic      cpu_rd;
	logic      cpu_wr;
	cpu_data_t cpu_dout;
	mem_addr_t mem_addr;
	cpu_data_t mem_dout;
	logic      mem_rd;
	logic      mem_wr;
	logic      dram_cs;
	logic      vram_cs;
	logic      bios_cs;
	logic      pbus_dma_trig;

	entry_t tbl[$];
	string  test_name [7] = '{"", "memory decode", "bios overlay", "control registers",
		"msb register", "player bus trigger", "dma stack"};
	bit     table_ready = 1'b0;
	int     checks = 0;
	int     errors = 0;
	int     err_mark = 0;	// errors before the current test
	int     tests_run = 0;
	int     tests_failed = 0;

	madam u_madam (
		.clk_25m       (clk_25m),
		.reset_n       (reset_n),
		.cpu_addr      (cpu_addr),
		.cpu_din       (cpu_din),
		.cpu_rd        (cpu_rd),
		.cpu_wr        (cpu_wr),
		.cpu_dout      (cpu_dout),
		.mem_addr      (mem_addr),
		.mem_dout      (mem_dout),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.dram_cs       (dram_cs),
		.vram_cs       (vram_cs),
		.bios_cs       (bios_cs),
		.pbus_dma_trig (pbus_dma_trig)
	);

	always #(CLK_NS / 2) clk_25m = ~clk_25m;	// 25 MHz

	task automatic check_data(input cpu_data_t got, input cpu_data_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s gave %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cs(input logic [2:0] got, input logic [2:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s chip selects %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_trig(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s pbus_dma_trig %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic add_entry(input logic [1:0] kind, input cpu_addr_t addr, input cpu_data_t data,
			input cpu_data_t exp, input logic trig, input logic [2:0] test);
		tbl.push_back('{kind, addr, data, exp, trig, test});
	endtask

	task automatic build_table();
		reg_off_t  offs [8];
		int        chans [3];
		cpu_data_t dma_exp [12];
		cpu_data_t d;
		offs  = '{16'h0008, 16'h000C, 16'h0040, 16'h0110, 16'h0130, 16'h0134, 16'h0138, 16'h013C};
		chans = '{0, 23, 31};
		add_entry(K_DEC, 32'h0010_0000, '0, 32'h5, 1'b0, 3'd1);	// dram shadowed by bios
		add_entry(K_DEC, 32'h0028_0000, '0, 32'h2, 1'b0, 3'd1);
		add_entry(K_DEC, 32'h0038_0000, '0, 32'h1, 1'b0, 3'd1);
		add_entry(K_DEC, 32'h0330_0008, '0, 32'h0, 1'b0, 3'd1);	// reg window, no mem
		add_entry(K_DEC, 32'h0040_0000, '0, 32'h0, 1'b0, 3'd1);	// just above 4 MB
		add_entry(K_WR,  32'h0000_1000, 32'h1234_5678, '0, 1'b0, 3'd2);	// unmaps bios
		add_entry(K_DEC, 32'h0010_0000, '0, 32'h4, 1'b0, 3'd2);
		add_entry(K_DEC, 32'h0038_0000, '0, 32'h1, 1'b0, 3'd2);
		add_entry(K_RD,  32'h0330_0000, '0, 32'h0102_0000, 1'b0, 3'd3);	// revision
		add_entry(K_RD,  32'h0330_0004, '0, 32'h0000_0029, 1'b0, 3'd3);	// msysbits
		for (int i = 0; i < 8; i++)	// bit 15 stays clear, low half is the offset
			add_entry(K_WR, {16'h0330, offs[i]}, {16'hA5C0 + 16'(i), offs[i]}, '0, 1'b0, 3'd3);
		for (int i = 0; i < 8; i++)
			add_entry(K_RD, {16'h0330, offs[i]}, '0, {16'hA5C0 + 16'(i), offs[i]}, 1'b0, 3'd3);
		add_entry(K_RD,  32'h0330_0014, '0, 32'hBADA_CCE5, 1'b0, 3'd3);	// unknown offset
		add_entry(K_WR,  32'h0330_002C, 32'h8400_0000, '0, 1'b0, 3'd4);
		add_entry(K_RD,  32'h0330_002C, '0, 32'd31, 1'b0, 3'd4);
		add_entry(K_WR,  32'h0330_002C, 32'h0000_0001, '0, 1'b0, 3'd4);
		add_entry(K_RD,  32'h0330_002C, '0, 32'd0, 1'b0, 3'd4);
		add_entry(K_WR,  32'h0330_002C, 32'h0000_0000, '0, 1'b0, 3'd4);
		add_entry(K_RD,  32'h0330_002C, '0, 32'hFFFF_FFFF, 1'b0, 3'd4);	// nothing set
		add_entry(K_WR,  32'h0330_0008, 32'h0000_8000, '0, 1'b0, 3'd5);
		add_entry(K_RD,  32'h0330_0008, '0, 32'h0000_8000, 1'b1, 3'd5);	// pulse cycle
		add_entry(K_RD,  32'h0330_0008, '0, 32'h0000_8000, 1'b0, 3'd5);	// gone again
		add_entry(K_WR,  32'h0330_0008, 32'h0000_0001, '0, 1'b0, 3'd5);
		add_entry(K_RD,  32'h0330_0008, '0, 32'h0000_0001, 1'b0, 3'd5);	// no pulse
		for (int c = 0; c < 3; c++) begin
			for (int f = 0; f < 4; f++) begin
				d = $urandom;
				dma_exp[c * 4 + f] = (f % 2 == 0) ? (d & 32'h003F_FFFF) : (d & 32'h00FF_FFFF);
				add_entry(K_WR, {16'h0330, 16'h0400 + 16'(chans[c] * 16 + f * 4)}, d, '0,
					1'b0, 3'd6);
			end
		end
		for (int c = 0; c < 3; c++)	// read back after all writes, catches aliasing
			for (int f = 0; f < 4; f++)
				add_entry(K_RD, {16'h0330, 16'h0400 + 16'(chans[c] * 16 + f * 4)}, '0,
					dma_exp[c * 4 + f], 1'b0, 3'd6);
		add_entry(K_RD,  32'h0330_0402, '0, 32'hBADA_CCE5, 1'b0, 3'd6);	// misaligned
	endtask

	task automatic report_test(input int id);
		tests_run++;
		if (errors != err_mark) begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", id, test_name[id], errors - err_mark);
		end else
			$display("test %0d %s: ok", id, test_name[id]);
		err_mark = errors;
	endtask

	initial begin
		clk_25m  = 1'b0;
		reset_n  = 1'b0;
		cpu_addr = '0;
		cpu_din  = '0;
		cpu_rd   = 1'b0;
		cpu_wr   = 1'b0;
		void'($urandom(32'hb40b_a8c1));	// one seed for the whole run
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_25m);
		reset_n <= 1'b1;
		for (int i = 0; i < tbl.size(); i++) begin
			@(posedge clk_25m);
			cpu_addr <= tbl[i].addr;
			cpu_din  <= tbl[i].data;
			cpu_wr   <= (tbl[i].kind == K_WR);
			cpu_rd   <= (tbl[i].kind != K_WR);
			@(negedge clk_25m);	// combinational outputs settled
			case (tbl[i].kind)
				K_RD: check_data(cpu_dout, tbl[i].exp, $sformatf("read %h", tbl[i].addr));
				K_DEC: begin
					check_cs({dram_cs, vram_cs, bios_cs}, tbl[i].exp[2:0],
						$sformatf("decode %h", tbl[i].addr));
					check_data(cpu_data_t'({mem_rd, mem_addr}),	// rd strobe over the address
						cpu_data_t'({tbl[i].addr < 32'h0040_0000, tbl[i].addr[21:0]}),
						$sformatf("mem port %h", tbl[i].addr));
				end
				default: begin
					check_data(mem_dout, tbl[i].data, $sformatf("write %h", tbl[i].addr));
					check_data(cpu_data_t'({mem_wr, mem_addr}),	// wr strobe over the address
						cpu_data_t'({tbl[i].addr < 32'h0040_0000, tbl[i].addr[21:0]}),
						$sformatf("mem write %h", tbl[i].addr));
				end
			endcase
			check_trig(pbus_dma_trig, tbl[i].trig, $sformatf("entry %0d", i));
			if (i == tbl.size() - 1 || tbl[i + 1].test != tbl[i].test)
				report_test(int'(tbl[i].test));
		end
		@(posedge clk_25m);
		cpu_rd <= 1'b0;
		cpu_wr <= 1'b0;
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// table length plus reset, with 20 cycles of margin
	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (tbl.size() + RESET_CYCLES + 20) * CLK_NS;
		#(limit_ns);
		$display("watchdog expired, run did not finish within %0d ns", limit_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: madam.sv
// ----------------------------------------------------------
// MADAM top, CPU interface only
// no cel, matrix, fence, mmu or dma mastering logic
// memory read data is not routed back through MADAM
// ----------------------------------------------------------
`timescale 1ns/1ps

module madam (
	input  logic                 clk_25m,
	input  logic                 reset_n,
	input  madam_pkg::cpu_addr_t cpu_addr,
	input  madam_pkg::cpu_data_t cpu_din,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,
	output madam_pkg::cpu_data_t cpu_dout,
	output madam_pkg::mem_addr_t mem_addr,
	output madam_pkg::cpu_data_t mem_dout,
	output logic                 mem_rd,
	output logic                 mem_wr,
	output logic                 dram_cs,
	output logic                 vram_cs,
	output logic                 bios_cs,
	output logic                 pbus_dma_trig
);

	import madam_pkg::*;

	logic      ctl_sel;	// control reg select
	logic      dma_sel;	// dma stack select
	reg_off_t  reg_off;
	cpu_data_t ctl_rdata;
	logic      ctl_hit;
	cpu_data_t dma_rdata;
	logic      dma_hit;

	madam_ctl_regs u_ctl_regs (
		.clk_25m       (clk_25m),
		.reset_n       (reset_n),
		.ctl_sel       (ctl_sel),
		.cpu_wr        (cpu_wr),
		.reg_off       (reg_off),
		.cpu_din       (cpu_din),
		.ctl_rdata     (ctl_rdata),
		.ctl_hit       (ctl_hit),
		.pbus_dma_trig (pbus_dma_trig)
	);

	madam_dma_stack u_dma_stack (
		.clk_25m   (clk_25m),
		.reset_n   (reset_n),
		.dma_sel   (dma_sel),
		.cpu_wr    (cpu_wr),
		.reg_off   (reg_off),
		.cpu_din   (cpu_din),
		.dma_rdata (dma_rdata),
		.dma_hit   (dma_hit)
	);

	madam_bus_arbiter u_bus_arbiter (
		.clk_25m   (clk_25m),
		.reset_n   (reset_n),
		.cpu_addr  (cpu_addr),
		.cpu_din   (cpu_din),
		.cpu_rd    (cpu_rd),
		.cpu_wr    (cpu_wr),
		.ctl_rdata (ctl_rdata),
		.ctl_hit   (ctl_hit),
		.dma_rdata (dma_rdata),
		.dma_hit   (dma_hit),
		.ctl_sel   (ctl_sel),
		.dma_sel   (dma_sel),
		.reg_off   (reg_off),
		.cpu_dout  (cpu_dout),
		.mem_addr  (mem_addr),
		.mem_dout  (mem_dout),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.dram_cs   (dram_cs),
		.vram_cs   (vram_cs),
		.bios_cs   (bios_cs)
	);

endmodule

// File: madam_bus_arbiter.sv
// ----------------------------------------------------------
// CPU-side address decode, BIOS overlay and memory port
// bios overlays dram from reset until the first dram write
// overlay covers the whole 2 MB dram range
// no dma master, memory port always carries the cpu access
// ----------------------------------------------------------
`timescale 1ns/1ps

module madam_bus_arbiter (
	input  logic                 clk_25m,
	input  logic                 reset_n,
	input  madam_pkg::cpu_addr_t cpu_addr,
	input  madam_pkg::cpu_data_t cpu_din,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,
	input  madam_pkg::cpu_data_t ctl_rdata,
	input  logic                 ctl_hit,
	input  madam_pkg::cpu_data_t dma_rdata,
	input  logic                 dma_hit,
	output logic                 ctl_sel,
	output logic                 dma_sel,
	output madam_pkg::reg_off_t  reg_off,
	output madam_pkg::cpu_data_t cpu_dout,
	output madam_pkg::mem_addr_t mem_addr,
	output madam_pkg::cpu_data_t mem_dout,
	output logic                 mem_rd,
	output logic                 mem_wr,
	output logic                 dram_cs,
	output logic                 vram_cs,
	output logic                 bios_cs
);

	import madam_pkg::*;

	logic dram_range;
	logic vram_range;
	logic bios_range;
	logic mem_range;	// anything below 4 MB
	logic reg_window;
	logic map_bios;		// bios shadows dram

	assign dram_range = cpu_addr inside {[DRAM_BASE:DRAM_LAST]};
	assign vram_range = cpu_addr inside {[VRAM_BASE:VRAM_LAST]};
	assign bios_range = cpu_addr inside {[BIOS_BASE:BIOS_LAST]};
	assign mem_range  = cpu_addr inside {[DRAM_BASE:BIOS_LAST]};
	assign reg_window = (cpu_addr[31:16] == REG_WINDOW);

	assign reg_off = cpu_addr[15:0];
	assign ctl_sel = reg_window && (reg_off < DMA_OFF_FIRST);
	assign dma_sel = reg_window && (reg_off inside {[DMA_OFF_FIRST:DMA_OFF_LAST]});

	assign dram_cs = dram_range;
	assign vram_cs = vram_range;
	assign bios_cs = bios_range || (dram_range && map_bios);	// both cs high while shadowed

	// memory port, straight from the cpu
	assign mem_addr = cpu_addr[$bits(mem_addr_t)-1:0];
	assign mem_dout = cpu_din;
	assign mem_rd   = cpu_rd && mem_range;
	assign mem_wr   = cpu_wr && mem_range;

	// first dram write unmaps the bios for good
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n)
			map_bios <= 1'b1;
		else if (cpu_wr && dram_range)
			map_bios <= 1'b0;
	end

	always_comb begin
		if (ctl_sel && ctl_hit)
			cpu_dout = ctl_rdata;
		else if (dma_sel && dma_hit)
			cpu_dout = dma_rdata;
		else
			cpu_dout = BAD_ACCESS_VALUE;	// unmapped or memory access
	end

endmodule

// File: madam_dma_stack.sv
// ----------------------------------------------------------
// DMA register stack, 32 channels of four fields each
// offset bits 8:4 pick the channel, bits 3:2 the field
// addresses keep 22 bits, lengths 24, upper bits read as zero
// misaligned offsets miss and are not written
// ----------------------------------------------------------
`timescale 1ns/1ps

module madam_dma_stack (
	input  logic                 clk_25m,
	input  logic                 reset_n,
	input  logic                 dma_sel,
	input  logic                 cpu_wr,
	input  madam_pkg::reg_off_t  reg_off,
	input  madam_pkg::cpu_data_t cpu_din,
	output madam_pkg::cpu_data_t dma_rdata,
	output logic                 dma_hit
);

	import madam_pkg::*;

	dma_addr_t cur_addr [DMA_CHANNELS];	// current address
	dma_len_t  cur_len  [DMA_CHANNELS];	// current length
	dma_addr_t nxt_addr [DMA_CHANNELS];	// next address
	dma_len_t  nxt_len  [DMA_CHANNELS];	// next length
	dma_chan_t chan;
	logic [1:0] field;
	logic      dma_wr;

	assign chan    = reg_off[8:4];
	assign field   = reg_off[3:2];
	assign dma_hit = (reg_off[1:0] == 2'b00);	// word aligned only
	assign dma_wr  = dma_sel && cpu_wr && dma_hit;

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < DMA_CHANNELS; i++) begin
				cur_addr[i] <= '0;
				cur_len[i]  <= '0;
				nxt_addr[i] <= '0;
				nxt_len[i]  <= '0;
			end
		end else if (dma_wr) begin
			case (field)	// upper data bits dropped
				2'd0: cur_addr[chan] <= cpu_din[$bits(dma_addr_t)-1:0];
				2'd1: cur_len[chan]  <= cpu_din[$bits(dma_len_t)-1:0];
				2'd2: nxt_addr[chan] <= cpu_din[$bits(dma_addr_t)-1:0];
				default: nxt_len[chan] <= cpu_din[$bits(dma_len_t)-1:0];
			endcase
		end
	end

	// zero-extended read of the selected field
	always_comb begin
		case (field)
			2'd0:    dma_rdata = cpu_data_t'(cur_addr[chan]);
			2'd1:    dma_rdata = cpu_data_t'(cur_len[chan]);
			2'd2:    dma_rdata = cpu_data_t'(nxt_addr[chan]);
			default: dma_rdata = cpu_data_t'(nxt_len[chan]);
		endcase
	end

endmodule

// File: madam_ctl_regs.sv
// ----------------------------------------------------------
// MADAM control and status registers
// write only happens with ctl_sel high, window is decoded upstream
// revision and msysbits are read-only constants
// pbus_dma_trig is a registered one-cycle pulse
// ----------------------------------------------------------
`timescale 1ns/1ps

module madam_ctl_regs (
	input  logic                 clk_25m,
	input  logic                 reset_n,
	input  logic                 ctl_sel,
	input  logic                 cpu_wr,
	input  madam_pkg::reg_off_t  reg_off,
	input  madam_pkg::cpu_data_t cpu_din,
	output madam_pkg::cpu_data_t ctl_rdata,
	output logic                 ctl_hit,
	output logic                 pbus_dma_trig
);

	import madam_pkg::*;

	cpu_data_t mctl;	// bit 15 kicks player bus dma
	cpu_data_t sltime;
	cpu_data_t abortbits;
	cpu_data_t privbits;
	cpu_data_t statbits;
	cpu_data_t msb_val;	// raw value behind msb_check
	cpu_data_t diag;
	cpu_data_t ccobctl0;
	cpu_data_t regctl0;
	cpu_data_t regctl1;
	cpu_data_t regctl2;
	cpu_data_t regctl3;
	logic      ctl_wr;

	// index of highest set bit, all ones when nothing set
	function automatic cpu_data_t msb_index(input cpu_data_t val);
		cpu_data_t idx;
		idx = MSB_NONE_VALUE;
		for (int i = 0; i < $bits(cpu_data_t); i++) begin
			if (val[i])
				idx = cpu_data_t'(i);	// later bits override
		end
		return idx;
	endfunction

	assign ctl_wr = ctl_sel && cpu_wr;

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			mctl          <= '0;
			sltime        <= '0;
			abortbits     <= '0;
			privbits      <= '0;
			statbits      <= '0;
			msb_val       <= '0;
			diag          <= '0;
			ccobctl0      <= '0;
			regctl0       <= '0;
			regctl1       <= '0;
			regctl2       <= '0;
			regctl3       <= '0;
			pbus_dma_trig <= 1'b0;
		end else begin
			// pulse for one cycle per mctl write with the pbus bit
			pbus_dma_trig <= ctl_wr && (reg_off == OFF_MCTL) && cpu_din[MCTL_PBUS_BIT];
			if (ctl_wr) begin
				case (reg_off)
					OFF_MCTL:      mctl      <= cpu_din;
					OFF_SLTIME:    sltime    <= cpu_din;
					OFF_ABORTBITS: abortbits <= cpu_din;
					OFF_PRIVBITS:  privbits  <= cpu_din;
					OFF_STATBITS:  statbits  <= cpu_din;
					OFF_MSB_CHECK: msb_val   <= cpu_din;
					OFF_DIAG:      diag      <= cpu_din;
					OFF_CCOBCTL0:  ccobctl0  <= cpu_din;
					OFF_REGCTL0:   regctl0   <= cpu_din;
					OFF_REGCTL1:   regctl1   <= cpu_din;
					OFF_REGCTL2:   regctl2   <= cpu_din;
					OFF_REGCTL3:   regctl3   <= cpu_din;
					default: ;	// revision write is bios debug output, dropped
				endcase
			end
		end
	end

	always_comb begin
		ctl_rdata = '0;
		ctl_hit   = 1'b1;
		case (reg_off)
			OFF_REVISION:  ctl_rdata = REVISION_VALUE;
			OFF_MSYSBITS:  ctl_rdata = MSYSBITS_VALUE;
			OFF_MCTL:      ctl_rdata = mctl;
			OFF_SLTIME:    ctl_rdata = sltime;
			OFF_ABORTBITS: ctl_rdata = abortbits;
			OFF_PRIVBITS:  ctl_rdata = privbits;
			OFF_STATBITS:  ctl_rdata = statbits;
			OFF_MSB_CHECK: ctl_rdata = msb_index(msb_val);	// index, not the value
			OFF_DIAG:      ctl_rdata = diag;
			OFF_CCOBCTL0:  ctl_rdata = ccobctl0;
			OFF_REGCTL0:   ctl_rdata = regctl0;
			OFF_REGCTL1:   ctl_rdata = regctl1;
			OFF_REGCTL2:   ctl_rdata = regctl2;
			OFF_REGCTL3:   ctl_rdata = regctl3;
			default:       ctl_hit   = 1'b0;	// arbiter returns bad access
		endcase
	end

endmodule

// File: madam_pkg.sv
// ----------------------------------------------------------
// shared types and constants for the MADAM CPU-side logic
// address map assumes 2 MB DRAM, 1 MB VRAM, 1 MB BIOS
// register window sits at upper address half 0x0330 only
// ----------------------------------------------------------
package madam_pkg;

	typedef logic [31:0] cpu_addr_t;	// cpu byte address
	typedef logic [31:0] cpu_data_t;	// cpu data word
	typedef logic [15:0] reg_off_t;		// offset inside reg window
	typedef logic [21:0] mem_addr_t;	// 4 MB memory port
	typedef logic [21:0] dma_addr_t;	// dma channel address
	typedef logic [23:0] dma_len_t;		// dma channel length
	typedef logic [4:0]  dma_chan_t;	// dma channel index

	// memory map
	localparam cpu_addr_t DRAM_BASE = 32'h0000_0000;	// 2 MB main dram
	localparam cpu_addr_t DRAM_LAST = 32'h001F_FFFF;
	localparam cpu_addr_t VRAM_BASE = 32'h0020_0000;	// 1 MB vram
	localparam cpu_addr_t VRAM_LAST = 32'h002F_FFFF;
	localparam cpu_addr_t BIOS_BASE = 32'h0030_0000;	// 1 MB bios rom
	localparam cpu_addr_t BIOS_LAST = 32'h003F_FFFF;

	localparam logic [15:0] REG_WINDOW    = 16'h0330;	// upper half of reg addresses
	localparam reg_off_t    DMA_OFF_FIRST = 16'h0400;	// dma stack, channel 0
	localparam reg_off_t    DMA_OFF_LAST  = 16'h05FC;	// last word of channel 31

	// control register offsets
	localparam reg_off_t OFF_REVISION  = 16'h0000;	// revision read, debug write
	localparam reg_off_t OFF_MSYSBITS  = 16'h0004;	// memory config
	localparam reg_off_t OFF_MCTL      = 16'h0008;	// dma channel enables
	localparam reg_off_t OFF_SLTIME    = 16'h000C;
	localparam reg_off_t OFF_ABORTBITS = 16'h0020;	// abort reasons
	localparam reg_off_t OFF_PRIVBITS  = 16'h0024;	// dma privilege violations
	localparam reg_off_t OFF_STATBITS  = 16'h0028;	// cel engine status
	localparam reg_off_t OFF_MSB_CHECK = 16'h002C;	// highest set bit finder
	localparam reg_off_t OFF_DIAG      = 16'h0040;
	localparam reg_off_t OFF_CCOBCTL0  = 16'h0110;	// cel engine control word
	localparam reg_off_t OFF_REGCTL0   = 16'h0130;	// frame buffer modulo
	localparam reg_off_t OFF_REGCTL1   = 16'h0134;	// x/y clip
	localparam reg_off_t OFF_REGCTL2   = 16'h0138;	// read base address
	localparam reg_off_t OFF_REGCTL3   = 16'h013C;	// write base address

	// fixed read values
	localparam cpu_data_t REVISION_VALUE   = 32'h0102_0000;
	localparam cpu_data_t MSYSBITS_VALUE   = 32'h0000_0029;	// 2 MB dram, 1 MB vram
	localparam cpu_data_t BAD_ACCESS_VALUE = 32'hBADA_CCE5;	// unmapped read
	localparam cpu_data_t MSB_NONE_VALUE   = 32'hFFFF_FFFF;	// msb of zero

	localparam int MCTL_PBUS_BIT = 15;	// player bus dma kick
	localparam int DMA_CHANNELS  = 32;

endpackage
